//--- common/foc_pkg.sv
`default_nettype none

package foc_pkg;

  localparam int data_w       = 16;
  localparam int q_bits       = 15;
  localparam int cordic_iters = 16;
  localparam int pwm_shift    = 13;
  localparam int out_lim      = 4096;

  // atan(2^-i) as a fraction of a full turn
  localparam logic [data_w-1:0] atan_table [cordic_iters] = '{
    16'd8192, 16'd4836, 16'd2555, 16'd1297, 16'd651, 16'd326, 16'd163, 16'd81,
    16'd41,   16'd20,   16'd10,   16'd5,    16'd3,   16'd1,   16'd1,   16'd0
  };

  localparam logic signed [data_w-1:0] cordic_gain_inv = 16'sd19898;
  localparam logic signed [data_w-1:0] inv_sqrt3_q15   = 16'sd18919;
  localparam logic signed [data_w-1:0] sqrt3_half_q15  = 16'sd28378;

  typedef struct packed {
    logic signed [data_w-1:0] a;
    logic signed [data_w-1:0] b;
    logic signed [data_w-1:0] c;
  } phase_t;

  typedef struct packed {
    logic signed [data_w-1:0] alpha;
    logic signed [data_w-1:0] beta;
  } ab_t;

  typedef struct packed {
    logic signed [data_w-1:0] d;
    logic signed [data_w-1:0] q;
  } dq_t;

  typedef struct packed {
    logic signed [data_w-1:0] sin;
    logic signed [data_w-1:0] cos;
  } sincos_t;

  typedef enum logic {reg_kp, reg_ki} pid_reg_e;

  typedef struct packed {
    logic              wen;
    logic              axis;  // 0 d, 1 q
    pid_reg_e          addr;
    logic [data_w-1:0] data;
  } pid_cfg_t;

  typedef enum logic [2:0] {st_idle, st_fwd, st_pid, st_inv, st_pwm} seq_state_e;

endpackage

`default_nettype wire

//--- src/foc_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module foc_sequencer import foc_pkg::*; (
  input  logic                     clk,
  input  logic                     rstb,
  input  logic                     valid_i,
  input  logic [data_w-1:0]        angle_i,
  input  phase_t                   curr_i,
  input  logic signed [data_w-1:0] target_i,
  input  logic [data_w-1:0]        period_i,
  input  logic                     fwd_done_i,
  input  logic                     pid_done_i,
  input  logic                     inv_done_i,
  input  logic                     pwm_taken_i,
  output logic                     ready_o,
  output logic [data_w-1:0]        angle_o,
  output phase_t                   curr_o,
  output logic signed [data_w-1:0] target_o,
  output logic [data_w-1:0]        period_o,
  output logic                     cordic_start_o,
  output logic                     pid_start_o,
  output logic                     inv_start_o,
  output logic                     pwm_load_o
);

  seq_state_e state_q;
  logic       accept;

  assign ready_o = (state_q == st_idle);
  assign accept  = valid_i && ready_o;  // valid ignored while busy

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      state_q        <= st_idle;
      cordic_start_o <= 1'b0;
      pid_start_o    <= 1'b0;
      inv_start_o    <= 1'b0;
      pwm_load_o     <= 1'b0;
    end else begin
      cordic_start_o <= accept;  // also kicks the forward transform
      pid_start_o    <= 1'b0;
      inv_start_o    <= 1'b0;
      pwm_load_o     <= 1'b0;
      case (state_q)
        st_idle: if (accept) state_q <= st_fwd;
        st_fwd: begin
          if (fwd_done_i) begin
            pid_start_o <= 1'b1;
            state_q     <= st_pid;
          end
        end
        st_pid: begin
          if (pid_done_i) begin
            inv_start_o <= 1'b1;
            state_q     <= st_inv;
          end
        end
        st_inv: begin
          if (inv_done_i) begin
            pwm_load_o <= 1'b1;
            state_q    <= st_pwm;
          end
        end
        st_pwm: if (pwm_taken_i) state_q <= st_idle;  // new duties applied
        default: state_q <= st_idle;
      endcase
    end
  end

  // sampled operands, held for the whole pass
  always_ff @(posedge clk) begin
    if (accept) begin
      angle_o  <= angle_i;
      curr_o   <= curr_i;
      target_o <= target_i;
    end
  end

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) period_o <= '0;
    else if (accept) period_o <= period_i;
  end

endmodule

`default_nettype wire

//--- cordic/cordic_sincos.sv
`timescale 1ns/100ps
`default_nettype none

module cordic_sincos import foc_pkg::*; (
  input  logic              clk,
  input  logic              rstb,
  input  logic              start_i,
  input  logic [data_w-1:0] angle_i,
  output logic              done_o,
  output sincos_t           sc_o
);

  logic signed [data_w+1:0]          x_q, y_q, z_q;  // two guard bits for gain growth
  logic signed [data_w+1:0]          sin_w, cos_w;
  logic [1:0]                        quad_q;
  logic [$clog2(cordic_iters)-1:0]   iter_q;
  logic                              busy_q;

  function automatic logic signed [data_w-1:0] sat_q15(input logic signed [data_w+1:0] v);
    if (v > 18'sd32767) return 16'sd32767;
    else if (v < -18'sd32767) return -16'sd32767;
    return v[data_w-1:0];
  endfunction

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      busy_q <= 1'b0;
      iter_q <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        iter_q <= '0;
      end else if (busy_q) begin
        iter_q <= iter_q + 1'b1;
        if (iter_q == cordic_iters - 1) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      x_q    <= (data_w+2)'(cordic_gain_inv);
      y_q    <= '0;
      z_q    <= $signed({4'b0000, angle_i[data_w-3:0]});  // angle within quadrant
      quad_q <= angle_i[data_w-1:data_w-2];
    end else if (busy_q) begin
      if (z_q[data_w+1]) begin
        x_q <= x_q + (y_q >>> iter_q);
        y_q <= y_q - (x_q >>> iter_q);
        z_q <= z_q + $signed({2'b00, atan_table[iter_q]});
      end else begin
        x_q <= x_q - (y_q >>> iter_q);
        y_q <= y_q + (x_q >>> iter_q);
        z_q <= z_q - $signed({2'b00, atan_table[iter_q]});
      end
    end
  end

  // unfold quadrant
  always_comb begin
    case (quad_q)
      2'd0: begin sin_w = y_q;  cos_w = x_q;  end
      2'd1: begin sin_w = x_q;  cos_w = -y_q; end
      2'd2: begin sin_w = -y_q; cos_w = -x_q; end
      default: begin sin_w = -x_q; cos_w = y_q; end
    endcase
    sc_o.sin = sat_q15(sin_w);
    sc_o.cos = sat_q15(cos_w);
  end

endmodule

`default_nettype wire

//--- transform/forward_transform.sv
`timescale 1ns/100ps
`default_nettype none

module forward_transform import foc_pkg::*; (
  input  logic    clk,
  input  logic    rstb,
  input  logic    start_i,
  input  phase_t  curr_i,
  input  logic    sc_valid_i,
  input  sincos_t sc_i,
  output logic    done_o,
  output dq_t     dq_o
);

  logic signed [data_w+1:0]   sum_ab;
  logic signed [2*data_w+2:0] beta_full;
  logic signed [data_w-1:0]   alpha_q, beta_q;
  logic signed [2*data_w-1:0] ac_q, bs_q, bc_q, as_q;
  logic signed [2*data_w:0]   d_sum, q_sum;
  logic                       wait_q, prod_q;

  // clarke, b-only form
  assign sum_ab    = (data_w+2)'(curr_i.a) + ((data_w+2)'(curr_i.b) <<< 1);
  assign beta_full = (2*data_w+3)'(sum_ab) * (2*data_w+3)'(inv_sqrt3_q15);

  assign d_sum = (2*data_w+1)'(ac_q) + (2*data_w+1)'(bs_q);
  assign q_sum = (2*data_w+1)'(bc_q) - (2*data_w+1)'(as_q);

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      wait_q <= 1'b0;
      prod_q <= 1'b0;
      done_o <= 1'b0;
    end else begin
      prod_q <= wait_q && sc_valid_i;
      done_o <= prod_q;
      if (start_i) wait_q <= 1'b1;
      else if (sc_valid_i) wait_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      alpha_q <= curr_i.a;
      beta_q  <= beta_full[q_bits +: data_w];
    end
    if (wait_q && sc_valid_i) begin  // park products once sin/cos land
      ac_q <= (2*data_w)'(alpha_q) * (2*data_w)'(sc_i.cos);
      bs_q <= (2*data_w)'(beta_q) * (2*data_w)'(sc_i.sin);
      bc_q <= (2*data_w)'(beta_q) * (2*data_w)'(sc_i.cos);
      as_q <= (2*data_w)'(alpha_q) * (2*data_w)'(sc_i.sin);
    end
    if (prod_q) begin
      dq_o.d <= d_sum[q_bits +: data_w];
      dq_o.q <= q_sum[q_bits +: data_w];
    end
  end

endmodule

`default_nettype wire

//--- transform/inverse_transform.sv
`timescale 1ns/100ps
`default_nettype none

module inverse_transform import foc_pkg::*; (
  input  logic    clk,
  input  logic    rstb,
  input  logic    start_i,
  input  dq_t     dq_i,
  input  sincos_t sc_i,
  output logic    done_o,
  output phase_t  v_o
);

  logic signed [2*data_w:0]   alpha_sum, beta_sum;
  logic signed [2*data_w:0]   beta_k;
  logic signed [data_w-1:0]   alpha_q, beta_q;
  logic signed [data_w-1:0]   half_alpha, beta_s;
  logic                       stage_q;

  // inverse park
  assign alpha_sum = (2*data_w+1)'(dq_i.d) * (2*data_w+1)'(sc_i.cos)
                   - (2*data_w+1)'(dq_i.q) * (2*data_w+1)'(sc_i.sin);
  assign beta_sum  = (2*data_w+1)'(dq_i.d) * (2*data_w+1)'(sc_i.sin)
                   + (2*data_w+1)'(dq_i.q) * (2*data_w+1)'(sc_i.cos);

  // inverse clarke terms
  assign beta_k     = (2*data_w+1)'(beta_q) * (2*data_w+1)'(sqrt3_half_q15);
  assign beta_s     = beta_k[q_bits +: data_w];
  assign half_alpha = alpha_q >>> 1;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      stage_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      stage_q <= start_i;
      done_o  <= stage_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      alpha_q <= alpha_sum[q_bits +: data_w];
      beta_q  <= beta_sum[q_bits +: data_w];
    end
    if (stage_q) begin
      v_o.a <= alpha_q;
      v_o.b <= beta_s - half_alpha;
      v_o.c <= -half_alpha - beta_s;
    end
  end

endmodule

`default_nettype wire

//--- pid/pid_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module pid_ctrl import foc_pkg::*; (
  input  logic                     clk,
  input  logic                     rstb,
  input  logic                     axis_i,
  input  pid_cfg_t                 cfg_i,
  input  logic                     start_i,
  input  logic signed [data_w-1:0] target_i,
  input  logic signed [data_w-1:0] meas_i,
  output logic                     done_o,
  output logic signed [data_w-1:0] out_o
);

  logic signed [data_w-1:0] kp_q, ki_q, integ_q;
  logic signed [data_w:0]   err;
  logic signed [2*data_w:0] p_full, i_full;
  logic signed [data_w+3:0] p_term, integ_sum, integ_next, out_sum;

  function automatic logic signed [data_w+3:0] clamp_lim(input logic signed [data_w+3:0] v);
    if (v > (data_w+4)'(out_lim)) return (data_w+4)'(out_lim);
    else if (v < -(data_w+4)'(out_lim)) return -(data_w+4)'(out_lim);
    return v;
  endfunction

  assign err    = (data_w+1)'(target_i) - (data_w+1)'(meas_i);
  assign p_full = (2*data_w+1)'(err) * (2*data_w+1)'(kp_q);
  assign i_full = (2*data_w+1)'(err) * (2*data_w+1)'(ki_q);

  assign p_term     = (data_w+4)'($signed(p_full[2*data_w:q_bits]));
  assign integ_sum  = (data_w+4)'(integ_q) + (data_w+4)'($signed(i_full[2*data_w:q_bits]));
  assign integ_next = clamp_lim(integ_sum);  // anti-windup
  assign out_sum    = clamp_lim(p_term + integ_next);

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      kp_q    <= '0;
      ki_q    <= '0;
      integ_q <= '0;
      out_o   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= start_i;
      if (cfg_i.wen && (cfg_i.axis == axis_i)) begin
        case (cfg_i.addr)
          reg_kp: kp_q <= cfg_i.data;
          reg_ki: ki_q <= cfg_i.data;
        endcase
      end
      if (start_i) begin
        integ_q <= integ_next[data_w-1:0];
        out_o   <= out_sum[data_w-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- pwm/svm_pwm.sv
`timescale 1ns/100ps
`default_nettype none

module svm_pwm import foc_pkg::*; (
  input  logic              clk,
  input  logic              rstb,
  input  logic              load_i,
  input  phase_t            v_i,
  input  logic [data_w-1:0] period_i,
  output logic              taken_o,
  output logic [2:0]        pwm_o
);

  logic signed [data_w-1:0]     v [3];
  logic signed [data_w-1:0]     vmax, vmin;
  logic signed [data_w:0]       offset, per_s, half_s;
  logic signed [data_w+1:0]     vo [3];
  logic signed [2*data_w+3:0]   scaled [3];
  logic [2:0][data_w-1:0]       cmp_new, cmp_pend_q, cmp_q;
  logic [data_w-1:0]            cnt_q;
  logic [data_w:0]              cnt_nxt;
  logic                         wrap, pend_q;

  assign v[0]   = v_i.a;
  assign v[1]   = v_i.b;
  assign v[2]   = v_i.c;
  assign per_s  = $signed({1'b0, period_i});
  assign half_s = $signed({2'b00, period_i[data_w-1:1]});

  always_comb begin
    vmax = v[0];
    vmin = v[0];
    for (int k = 1; k < 3; k++) begin
      if (v[k] > vmax) vmax = v[k];
      if (v[k] < vmin) vmin = v[k];
    end
    offset = -(((data_w+1)'(vmax) + (data_w+1)'(vmin)) >>> 1);  // common-mode injection
    for (int k = 0; k < 3; k++) begin
      vo[k]     = (data_w+2)'(v[k]) + (data_w+2)'(offset);
      scaled[k] = (((2*data_w+4)'(vo[k]) * (2*data_w+4)'(per_s)) >>> pwm_shift)
                + (2*data_w+4)'(half_s);
      if (scaled[k] < 0) cmp_new[k] = '0;
      else if (scaled[k] > (2*data_w+4)'(per_s)) cmp_new[k] = period_i;
      else cmp_new[k] = scaled[k][data_w-1:0];
    end
  end

  // carrier 0 .. period-1
  assign cnt_nxt = {1'b0, cnt_q} + 1'b1;
  assign wrap    = (cnt_nxt >= {1'b0, period_i});

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) begin
      cnt_q   <= '0;
      cmp_q   <= '0;
      pend_q  <= 1'b0;
      taken_o <= 1'b0;
    end else begin
      taken_o <= 1'b0;
      cnt_q   <= wrap ? '0 : cnt_nxt[data_w-1:0];
      if (wrap && pend_q) begin
        cmp_q   <= cmp_pend_q;
        pend_q  <= 1'b0;
        taken_o <= 1'b1;
      end
      if (load_i) pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) cmp_pend_q <= cmp_new;
  end

  always_comb begin
    for (int k = 0; k < 3; k++) pwm_o[k] = (cnt_q < cmp_q[k]);
  end

endmodule

`default_nettype wire

//--- src/foc_top.sv
`timescale 1ns/100ps
`default_nettype none

module foc_top import foc_pkg::*; (
  input  logic                     clk,
  input  logic                     rstb,
  input  logic                     valid_i,
  input  logic [data_w-1:0]        angle_i,
  input  phase_t                   curr_i,
  input  logic signed [data_w-1:0] target_i,
  input  logic [data_w-1:0]        period_i,
  input  pid_cfg_t                 cfg_i,
  output logic                     ready_o,
  output logic [2:0]               pwm_o
);

  logic [data_w-1:0]        angle_r, period_r;
  logic signed [data_w-1:0] target_r, v_d, v_q;
  phase_t                   curr_r, v_abc;
  sincos_t                  sc;
  dq_t                      i_dq, v_dq;
  logic                     cordic_start, cordic_done, fwd_done;
  logic                     pid_start, pid_done, inv_start, inv_done;
  logic                     pwm_load, pwm_taken;

  assign v_dq = {v_d, v_q};

  foc_sequencer seq_i (
    .clk(clk), .rstb(rstb), .valid_i(valid_i), .angle_i(angle_i), .curr_i(curr_i),
    .target_i(target_i), .period_i(period_i), .fwd_done_i(fwd_done),
    .pid_done_i(pid_done), .inv_done_i(inv_done), .pwm_taken_i(pwm_taken),
    .ready_o(ready_o), .angle_o(angle_r), .curr_o(curr_r), .target_o(target_r),
    .period_o(period_r), .cordic_start_o(cordic_start), .pid_start_o(pid_start),
    .inv_start_o(inv_start), .pwm_load_o(pwm_load)
  );

  cordic_sincos cordic_i (
    .clk(clk), .rstb(rstb), .start_i(cordic_start), .angle_i(angle_r),
    .done_o(cordic_done), .sc_o(sc)
  );

  forward_transform fwd_i (
    .clk(clk), .rstb(rstb), .start_i(cordic_start), .curr_i(curr_r),
    .sc_valid_i(cordic_done), .sc_i(sc), .done_o(fwd_done), .dq_o(i_dq)
  );

  pid_ctrl pid_d (
    .clk(clk), .rstb(rstb), .axis_i(1'b0), .cfg_i(cfg_i), .start_i(pid_start),
    .target_i('0), .meas_i(i_dq.d), .done_o(), .out_o(v_d)
  );

  pid_ctrl pid_q (
    .clk(clk), .rstb(rstb), .axis_i(1'b1), .cfg_i(cfg_i), .start_i(pid_start),
    .target_i(target_r), .meas_i(i_dq.q), .done_o(pid_done), .out_o(v_q)
  );

  inverse_transform inv_i (
    .clk(clk), .rstb(rstb), .start_i(inv_start), .dq_i(v_dq), .sc_i(sc),
    .done_o(inv_done), .v_o(v_abc)
  );

  svm_pwm pwm_i (
    .clk(clk), .rstb(rstb), .load_i(pwm_load), .v_i(v_abc), .period_i(period_r),
    .taken_o(pwm_taken), .pwm_o(pwm_o)
  );

endmodule

`default_nettype wire

//--- sim/foc_assert.sv
`timescale 1ns/100ps
`default_nettype none

module foc_assert import foc_pkg::*; (
  input logic              clk,
  input logic              rstb,
  input logic              ready_i,
  input logic [2:0]        pwm_i,
  input logic [data_w-1:0] period_i
);

  logic [data_w:0] busy_cnt;  // cycles since ready fell
  int unsigned     fail_cnt = 0;

  always_ff @(posedge clk or negedge rstb) begin
    if (!rstb) busy_cnt <= '0;
    else if (ready_i) busy_cnt <= '0;
    else if (busy_cnt != '1) busy_cnt <= busy_cnt + 1'b1;
  end

  // outputs idle while reset is held
  reset_idle: assert property (@(posedge clk) !rstb |-> (pwm_i == 3'b000 && ready_i))
    else begin
      $error("pwm_o active or ready_o low during reset");
      fail_cnt++;
    end

  pass_ends: assert property (@(posedge clk) disable iff (!rstb)
      busy_cnt <= period_i + 17'd40)
    else begin
      $error("ready_o stayed low longer than period_i + 40 cycles");
      fail_cnt++;
    end

endmodule

bind foc_top foc_assert foc_assert_i (
  .clk(clk), .rstb(rstb), .ready_i(ready_o), .pwm_i(pwm_o), .period_i(period_i)
);

`default_nettype wire

//--- sim/foc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module foc_tb import foc_pkg::*; ();

  localparam int period   = 160;
  localparam int pass_cnt = 31;
  // each pass takes up to one carrier period to apply the duties and one more to measure
  localparam int watchdog_cycles = pass_cnt * (2 * period + 40) + 2 * period + 200;

  logic                     clk, rstb, valid_i, ready_o;
  logic [data_w-1:0]        angle_i, period_i;
  logic signed [data_w-1:0] target_i;
  phase_t                   curr_i;
  pid_cfg_t                 cfg_i;
  logic [2:0]               pwm_o;

  integer                 seed;
  int                     err_cnt;
  int                     checked;
  logic [2:0][data_w-1:0] exp_q [$];
  longint                 kp_m [2], ki_m [2], integ_m [2];  // index 0 d, 1 q

  foc_top foc_top_i (
    .clk(clk), .rstb(rstb), .valid_i(valid_i), .angle_i(angle_i), .curr_i(curr_i),
    .target_i(target_i), .period_i(period_i), .cfg_i(cfg_i), .ready_o(ready_o),
    .pwm_o(pwm_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic longint wrap16(input longint v);
    logic signed [data_w-1:0] t;
    t = v[data_w-1:0];
    return t;
  endfunction

  function automatic longint clamp(input longint v, input longint lo, input longint hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  // expected compares for one pass with the integrators advancing as in hardware
  function automatic logic [2:0][data_w-1:0] foc_model(input longint ang, input longint ia,
      input longint ib, input longint tgt);
    longint x, y, z, xn, quad, s, c, beta, id, iq, err, p, al, be, bs, vmax, vmin, off, cmp;
    longint v [2];
    longint ph [3];
    int     i;
    logic [2:0][data_w-1:0] res;
    x = cordic_gain_inv;
    y = 0;
    z = ang & 16'h3fff;
    quad = (ang >> 14) & 3;
    for (i = 0; i < cordic_iters; i++) begin
      if (z < 0) begin
        xn = x + (y >>> i);
        y  = y - (x >>> i);
        z  = z + longint'(atan_table[i]);
      end else begin
        xn = x - (y >>> i);
        y  = y + (x >>> i);
        z  = z - longint'(atan_table[i]);
      end
      x = xn;
    end
    case (quad)
      0: begin s = y;  c = x;  end
      1: begin s = x;  c = -y; end
      2: begin s = -y; c = -x; end
      default: begin s = -x; c = y; end
    endcase
    s = clamp(s, -32767, 32767);
    c = clamp(c, -32767, 32767);
    beta = wrap16(((ia + 2 * ib) * inv_sqrt3_q15) >>> q_bits);
    id = wrap16((ia * c + beta * s) >>> q_bits);
    iq = wrap16((beta * c - ia * s) >>> q_bits);
    for (i = 0; i < 2; i++) begin
      err = (i == 1) ? tgt - iq : -id;  // d target is 0
      p = (err * kp_m[i]) >>> q_bits;
      integ_m[i] = clamp(integ_m[i] + ((err * ki_m[i]) >>> q_bits), -out_lim, out_lim);
      v[i] = clamp(p + integ_m[i], -out_lim, out_lim);
    end
    al = wrap16((v[0] * c - v[1] * s) >>> q_bits);
    be = wrap16((v[0] * s + v[1] * c) >>> q_bits);
    bs = wrap16((be * sqrt3_half_q15) >>> q_bits);
    ph[0] = al;
    ph[1] = wrap16(bs - (al >>> 1));
    ph[2] = wrap16(-(al >>> 1) - bs);
    vmax = ph[0];
    vmin = ph[0];
    for (i = 1; i < 3; i++) begin
      if (ph[i] > vmax) vmax = ph[i];
      if (ph[i] < vmin) vmin = ph[i];
    end
    off = -((vmax + vmin) >>> 1);
    for (i = 0; i < 3; i++) begin
      cmp = (((ph[i] + off) * period) >>> pwm_shift) + period / 2;
      res[i] = data_w'(clamp(cmp, 0, period));
    end
    return res;
  endfunction

  task automatic write_gain(input int axis, input pid_reg_e addr, input int value);
    @(posedge clk);
    #1;
    cfg_i.wen  = 1'b1;
    cfg_i.axis = axis[0];
    cfg_i.addr = addr;
    cfg_i.data = value[data_w-1:0];
    @(posedge clk);
    #1;
    cfg_i.wen = 1'b0;
    if (addr == reg_kp) kp_m[axis] = value;
    else ki_m[axis] = value;
  endtask

  task automatic run_pass(input logic [data_w-1:0] ang, input int ia, input int ib,
      input int ic, input int tgt, input logic [2:0][data_w-1:0] expect_cmp, input bit stray);
    int n;
    n = checked + 1;
    exp_q.push_back(expect_cmp);
    @(posedge clk);
    #1;
    valid_i  = 1'b1;
    angle_i  = ang;
    curr_i.a = ia[data_w-1:0];
    curr_i.b = ib[data_w-1:0];
    curr_i.c = ic[data_w-1:0];
    target_i = tgt[data_w-1:0];
    @(posedge clk);
    #1;
    valid_i = 1'b0;
    if (stray) begin
      repeat (5) @(posedge clk);
      #1;
      if (ready_o !== 1'b0) begin
        $display("mismatch ready_o: got %h expected 0", ready_o);
        err_cnt++;
      end
      valid_i  = 1'b1;  // must be dropped while busy
      angle_i  = ~ang;
      curr_i   = '{a: 16'sd3000, b: -16'sd2500, c: -16'sd500};
      target_i = -16'sd9000;
      @(posedge clk);
      #1;
      valid_i = 1'b0;
    end
    wait (checked == n);
  endtask

  initial begin : stimulus
    int                ia, ib, ic, total;
    logic [data_w-1:0] ang;
    seed = 32'he419_cfc8;
    err_cnt = 0;
    checked = 0;
    kp_m = '{0, 0};
    ki_m = '{0, 0};
    integ_m = '{0, 0};
    rstb = 1'b1;
    valid_i = 1'b0;
    angle_i = '0;
    curr_i = '0;
    target_i = '0;
    period_i = period[data_w-1:0];
    cfg_i = '0;
    #1 rstb = 1'b0;
    repeat (8) @(posedge clk);
    #1 rstb = 1'b1;

    // idle after reset
    repeat (2 * period) begin
      @(negedge clk);
      if (ready_o !== 1'b1) begin
        $display("mismatch ready_o: got %h expected 1", ready_o);
        err_cnt++;
      end
      if (pwm_o !== 3'b000) begin
        $display("mismatch pwm_o: got %h expected 0", pwm_o);
        err_cnt++;
      end
    end

    // zero gains give zero voltage and half duty
    write_gain(0, reg_kp, 0);
    write_gain(0, reg_ki, 0);
    write_gain(1, reg_kp, 0);
    write_gain(1, reg_ki, 0);
    run_pass(16'h1234, 900, -400, -500, 2000, {3{data_w'(period / 2)}}, 1'b0);

    write_gain(1, reg_kp, 20000);
    repeat (20) begin
      ang = $random(seed);
      ia = $random(seed) % 8192;
      ib = $random(seed) % 8192;
      ic = -ia - ib;
      run_pass(ang, ia, ib, ic, 1000, foc_model(ang, ia, ib, 1000), 1'b0);
    end

    // integrator builds up and then hits the clamp
    write_gain(1, reg_kp, 8192);
    write_gain(1, reg_ki, 6000);
    repeat (3) run_pass(16'h2345, 1200, -700, -500, 1500,
                        foc_model(16'h2345, 1200, -700, 1500), 1'b0);
    repeat (3) run_pass(16'h2345, 1200, -700, -500, 30000,
                        foc_model(16'h2345, 1200, -700, 30000), 1'b0);

    run_pass(16'h6a00, -800, 300, 500, 1500, foc_model(16'h6a00, -800, 300, 1500), 1'b1);
    run_pass(16'hc180, 400, 600, -1000, 1500, foc_model(16'hc180, 400, 600, 1500), 1'b0);

    // only d gains active
    write_gain(1, reg_kp, 0);
    write_gain(1, reg_ki, 0);
    write_gain(0, reg_kp, 15000);
    write_gain(0, reg_ki, 3000);
    repeat (2) begin
      ang = $random(seed);
      ia = $random(seed) % 8192;
      ib = $random(seed) % 8192;
      ic = -ia - ib;
      run_pass(ang, ia, ib, ic, 500, foc_model(ang, ia, ib, 500), 1'b0);
    end

    total = err_cnt + foc_top_i.foc_assert_i.fail_cnt;
    $display("passes checked %0d, check errors %0d, assertion errors %0d",
             checked, err_cnt, foc_top_i.foc_assert_i.fail_cnt);
    if (total == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

  // high cycles per phase over one carrier period once the pass is done
  initial begin : compare_duty
    int                     high_cnt [3];
    int                     k;
    logic [2:0][data_w-1:0] expect_cmp;
    wait (rstb === 1'b0);
    wait (rstb === 1'b1);
    forever begin
      @(negedge clk);
      if (!ready_o) begin
        while (!ready_o) @(negedge clk);
        high_cnt = '{0, 0, 0};
        repeat (period) begin
          for (k = 0; k < 3; k++) begin
            if (pwm_o[k]) high_cnt[k] += 1;
          end
          @(negedge clk);
        end
        if (exp_q.size() == 0) begin
          $display("error: a pass finished but none was started");
          err_cnt++;
        end else begin
          expect_cmp = exp_q.pop_front();
          for (k = 0; k < 3; k++) begin
            if (high_cnt[k] != int'(expect_cmp[k])) begin
              $display("mismatch pwm_o[%0d] high cycles: got %h expected %h",
                       k, high_cnt[k], expect_cmp[k]);
              err_cnt++;
            end
          end
        end
        checked++;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/foc_pkg.sv
src/foc_sequencer.sv
cordic/cordic_sincos.sv
transform/forward_transform.sv
transform/inverse_transform.sv
pid/pid_ctrl.sv
pwm/svm_pwm.sv
src/foc_top.sv
sim/foc_assert.sv
sim/foc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= foc_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LINT_OPTS ?= --lint-only -Wall --timing
SIM_OPTS  ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_OPTS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
